// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int imem_words = 256;                    // program rom depth in words
  localparam int imem_aw = $clog2(imem_words);        // rom word index width
  localparam int dmem_bytes = 2048;                   // data ram size
  localparam int dmem_word_aw = $clog2(dmem_bytes / 8); // dword index width
  localparam logic [63:0] dmem_base = 64'h1000;       // data ram base address
  localparam logic [63:0] reset_pc = 64'h0;           // first fetch address
  localparam logic [63:0] cause_ecall = 64'd11;       // ecall from m-mode
  localparam int mstatus_mie = 3;                     // global irq enable bit
  localparam int mstatus_mpie = 7;                    // saved mie bit

  localparam logic [31:0] instr_ecall = 32'h0000_0073;
  localparam logic [31:0] instr_ebreak = 32'h0010_0073;
  localparam logic [31:0] instr_mret = 32'h3020_0073;

  typedef enum logic [2:0] {
    idle_st,
    fetch_st,
    exec_st,
    mem_st,
    wb_st,
    halt_st
  } state_e;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_e;

  // same encoding as load/store funct3
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_d  = 3'b011,
    mem_bu = 3'b100,
    mem_hu = 3'b101,
    mem_wu = 3'b110
  } mem_op_e;

  typedef enum logic [11:0] {
    csr_mstatus = 12'h300,
    csr_mtvec   = 12'h305,
    csr_mepc    = 12'h341,
    csr_mcause  = 12'h342
  } csr_addr_e;

endpackage

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [4:0]  rs1,
  input  wire logic [4:0]  rs2,
  output logic      [63:0] rs1_data,
  output logic      [63:0] rs2_data,
  input  wire logic        we,
  input  wire logic [4:0]  rd,
  input  wire logic [63:0] rd_data
);

  logic [63:0] regs [1:31]; // x0 has no storage

  assign rs1_data = (rs1 == 5'd0) ? 64'd0 : regs[rs1]; // x0 hardwired zero
  assign rs2_data = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 64'd0;
      end
    end else if (we && (rd != 5'd0)) begin // drop x0 writes
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_csr.sv
`timescale 1ns/100ps
`default_nettype none

module rv_csr (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        csr_wr,
  input  wire logic [11:0] csr_addr,
  input  wire logic [63:0] csr_wdata,
  output logic      [63:0] csr_rdata,
  output logic             csr_hit,
  input  wire logic        trap_take,
  input  wire logic [63:0] trap_pc,
  input  wire logic        mret_take,
  output logic      [63:0] mstatus,
  output logic      [63:0] mtvec,
  output logic      [63:0] mepc,
  output logic      [63:0] mcause
);

  // read mux and address decode
  always_comb begin
    csr_hit = 1'b1;
    csr_rdata = 64'd0;
    case (csr_addr)
      rv_pkg::csr_mstatus: csr_rdata = mstatus;
      rv_pkg::csr_mtvec:   csr_rdata = mtvec;
      rv_pkg::csr_mepc:    csr_rdata = mepc;
      rv_pkg::csr_mcause:  csr_rdata = mcause;
      default:             csr_hit = 1'b0; // core flags illegal
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= 64'd0;
      mtvec   <= 64'd0;
      mepc    <= 64'd0;
      mcause  <= 64'd0;
    end else if (trap_take) begin
      mepc <= trap_pc;                 // pc of the ecall itself
      mcause <= rv_pkg::cause_ecall;
      mstatus[rv_pkg::mstatus_mpie] <= mstatus[rv_pkg::mstatus_mie]; // stack mie
      mstatus[rv_pkg::mstatus_mie] <= 1'b0;
    end else if (mret_take) begin
      mstatus[rv_pkg::mstatus_mie] <= mstatus[rv_pkg::mstatus_mpie]; // pop mie
      mstatus[rv_pkg::mstatus_mpie] <= 1'b1;
    end else if (csr_wr) begin
      case (csr_addr)
        rv_pkg::csr_mstatus: mstatus <= csr_wdata;
        rv_pkg::csr_mtvec:   mtvec <= csr_wdata;
        rv_pkg::csr_mepc:    mepc <= csr_wdata;
        rv_pkg::csr_mcause:  mcause <= csr_wdata;
        default:             ; // unknown address never written
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core (
  input  wire logic        clk,
  input  wire logic        rst,
  output logic             fetch_req,
  output logic      [63:0] fetch_pc,
  input  wire logic        instr_valid,
  input  wire logic [31:0] instr,
  input  wire logic        instr_error,
  output logic             mem_rd,
  output logic             mem_wr,
  output logic      [63:0] mem_addr,
  output rv_pkg::mem_op_e  mem_op,
  output logic      [63:0] wr_data,
  input  wire logic        rd_valid,
  input  wire logic [63:0] rd_data,
  input  wire logic        rd_error,
  input  wire logic        wr_error,
  output logic             retire_valid,
  output logic      [63:0] retire_pc,
  output logic      [4:0]  retire_rd,
  output logic      [63:0] retire_data,
  output logic      [63:0] pc_done,
  output logic             done,
  output logic             error,
  output logic      [63:0] mepc,
  output logic      [63:0] mcause
);

  rv_pkg::state_e state;
  rv_pkg::opcode_e opcode;
  logic [63:0] pc;
  logic [31:0] ir;                 // held for the mem_st cycle
  logic [31:0] cur;                // word under decode
  logic [2:0] funct3;
  logic [4:0] rs1, rs2, wb_rd;
  logic [63:0] rs1_data, rs2_data;
  logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [63:0] result, next_pc, mtvec, csr_rdata;
  logic is_load, is_store, is_branch, is_jal, is_ecall, is_ebreak, is_mret, is_csrrw;
  logic legal, writes_rd, taken, exec_ok;
  logic csr_hit, csr_wr, trap_take, mret_take;

  assign cur = (state == rv_pkg::exec_st) ? instr : ir; // fresh word only in exec
  assign opcode = rv_pkg::opcode_e'(cur[6:0]);
  assign funct3 = cur[14:12];
  assign rs1 = cur[19:15];
  assign rs2 = cur[24:20];
  assign imm_i = {{52{cur[31]}}, cur[31:20]};
  assign imm_s = {{52{cur[31]}}, cur[31:25], cur[11:7]};
  assign imm_b = {{52{cur[31]}}, cur[7], cur[30:25], cur[11:8], 1'b0};
  assign imm_u = {{32{cur[31]}}, cur[31:12], 12'd0};
  assign imm_j = {{44{cur[31]}}, cur[19:12], cur[20], cur[30:21], 1'b0};

  // decode and alu
  always_comb begin
    {is_load, is_store, is_branch, is_jal} = 4'b0000;
    {is_ecall, is_ebreak, is_mret, is_csrrw} = 4'b0000;
    legal = 1'b0;
    writes_rd = 1'b0;
    result = 64'd0;
    case (opcode)
      rv_pkg::op_lui: begin
        legal = 1'b1;
        writes_rd = 1'b1;
        result = imm_u;
      end
      rv_pkg::op_imm: begin
        legal = (funct3 == 3'b000); // addi only
        writes_rd = 1'b1;
        result = rs1_data + imm_i;
      end
      rv_pkg::op_reg: begin
        legal = (funct3 == 3'b000) && ((cur[31:25] == 7'h00) || (cur[31:25] == 7'h20));
        writes_rd = 1'b1;
        result = cur[30] ? rs1_data - rs2_data : rs1_data + rs2_data; // sub : add
      end
      rv_pkg::op_load: begin
        is_load = (funct3 != 3'b111); // no ldu
        legal = is_load;
        writes_rd = 1'b1;
      end
      rv_pkg::op_store: begin
        is_store = !funct3[2];
        legal = is_store;
      end
      rv_pkg::op_branch: begin
        is_branch = (funct3[2:1] == 2'b00); // beq bne
        legal = is_branch;
      end
      rv_pkg::op_jal: begin
        is_jal = 1'b1;
        legal = 1'b1;
        writes_rd = 1'b1;
        result = pc + 64'd4; // link address
      end
      rv_pkg::op_system: begin
        is_ecall = (cur == rv_pkg::instr_ecall);
        is_ebreak = (cur == rv_pkg::instr_ebreak);
        is_mret = (cur == rv_pkg::instr_mret);
        is_csrrw = (funct3 == 3'b001) && csr_hit;
        legal = is_ecall || is_ebreak || is_mret || is_csrrw;
        writes_rd = is_csrrw;
        result = csr_rdata; // old csr value
      end
      default: ;
    endcase
  end

  assign taken = is_branch && ((rs1_data == rs2_data) ^ funct3[0]); // f3[0] inverts for bne
  assign wb_rd = writes_rd ? cur[11:7] : 5'd0;
  assign exec_ok = instr_valid && !instr_error && legal;

  always_comb begin
    if (is_ecall) next_pc = mtvec;
    else if (is_mret) next_pc = mepc;
    else if (is_jal) next_pc = pc + imm_j;
    else if (taken) next_pc = pc + imm_b;
    else next_pc = pc + 64'd4;
  end

  assign fetch_req = (state == rv_pkg::fetch_st);
  assign fetch_pc = pc;
  assign mem_rd = (state == rv_pkg::exec_st) && exec_ok && is_load; // answer lands in mem_st
  assign mem_wr = (state == rv_pkg::mem_st) && is_store;
  assign mem_addr = rs1_data + (is_store ? imm_s : imm_i);
  assign mem_op = rv_pkg::mem_op_e'(funct3);
  assign wr_data = rs2_data;
  assign csr_wr = (state == rv_pkg::exec_st) && exec_ok && is_csrrw;
  assign trap_take = (state == rv_pkg::exec_st) && exec_ok && is_ecall;
  assign mret_take = (state == rv_pkg::exec_st) && exec_ok && is_mret;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pkg::idle_st;
      pc <= rv_pkg::reset_pc;
      retire_valid <= 1'b0;
      done <= 1'b0;
      error <= 1'b0;
    end else begin
      retire_valid <= 1'b0; // single cycle pulse
      case (state)
        rv_pkg::idle_st:  state <= rv_pkg::fetch_st;
        rv_pkg::fetch_st: state <= rv_pkg::exec_st;
        rv_pkg::exec_st: begin
          ir <= instr;
          retire_pc <= pc;
          retire_rd <= wb_rd;
          retire_data <= (wb_rd == 5'd0) ? 64'd0 : result;
          if (!exec_ok) begin // bad fetch or illegal encoding
            state <= rv_pkg::halt_st;
            error <= 1'b1;
            pc_done <= pc;
          end else if (is_ebreak) begin
            state <= rv_pkg::halt_st;
            done <= 1'b1;
            pc_done <= pc;
          end else begin
            pc <= next_pc;
            if (is_load || is_store) begin
              state <= rv_pkg::mem_st;
            end else begin
              state <= rv_pkg::wb_st;
              retire_valid <= 1'b1;
            end
          end
        end
        rv_pkg::mem_st: begin
          if (is_store ? wr_error : (rd_error || !rd_valid)) begin
            state <= rv_pkg::halt_st;
            error <= 1'b1;
            pc_done <= retire_pc; // pc already advanced
          end else begin
            if (!is_store) begin
              retire_data <= (retire_rd == 5'd0) ? 64'd0 : rd_data;
            end
            state <= rv_pkg::wb_st;
            retire_valid <= 1'b1;
          end
        end
        rv_pkg::wb_st: state <= rv_pkg::fetch_st;
        default:       state <= rv_pkg::halt_st; // parked until reset
      endcase
    end
  end

  rv_regfile u_regfile (
    .clk(clk), .rst(rst),
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(retire_valid), .rd(retire_rd), .rd_data(retire_data) // writeback from retire stage
  );

  // no interrupts so mstatus is left unread here
  rv_csr u_csr (
    .clk(clk), .rst(rst),
    .csr_wr(csr_wr), .csr_addr(cur[31:20]), .csr_wdata(rs1_data),
    .csr_rdata(csr_rdata), .csr_hit(csr_hit),
    .trap_take(trap_take), .trap_pc(pc), .mret_take(mret_take),
    .mstatus(), .mtvec(mtvec), .mepc(mepc), .mcause(mcause)
  );

endmodule

`default_nettype wire

// File: logic/rv_imem.sv
`timescale 1ns/100ps
`default_nettype none

module rv_imem (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      load_valid,
  input  wire logic [rv_pkg::imem_aw-1:0] load_addr,
  input  wire logic [31:0]               load_data,
  input  wire logic                      fetch_req,
  input  wire logic [63:0]               fetch_pc,
  output logic                           instr_valid,
  output logic      [31:0]               instr,
  output logic                           instr_error
);

  logic [31:0] rom [rv_pkg::imem_words];
  logic fetch_ok;

  // word aligned and inside the rom
  assign fetch_ok = (fetch_pc[1:0] == 2'b00) && (fetch_pc[63:2] < 62'(rv_pkg::imem_words));

  always_ff @(posedge clk) begin
    if (rst && load_valid) begin // loader only while core held
      rom[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      instr_valid <= 1'b0;
      instr_error <= 1'b0;
    end else begin
      instr_valid <= fetch_req && fetch_ok;
      instr_error <= fetch_req && !fetch_ok;
    end
    if (fetch_req) begin
      instr <= rom[fetch_pc[rv_pkg::imem_aw+1:2]];
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_dmem.sv
`timescale 1ns/100ps
`default_nettype none

module rv_dmem (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        mem_rd,
  input  wire logic        mem_wr,
  input  wire logic [63:0] mem_addr,
  input  var rv_pkg::mem_op_e mem_op,
  input  wire logic [63:0] wr_data,
  output logic             rd_valid,
  output logic      [63:0] rd_data,
  output logic             rd_error,
  output logic             wr_error
);

  logic [63:0] ram [2**rv_pkg::dmem_word_aw]; // one dword per row
  logic [63:0] offset;
  logic [rv_pkg::dmem_word_aw-1:0] idx;
  logic [2:0] lane;
  logic [3:0] nbytes;
  logic [7:0] size_mask, wmask;
  logic [63:0] wshift, rword;
  logic ok;

  assign offset = mem_addr - rv_pkg::dmem_base; // below base wraps to huge
  assign idx = offset[rv_pkg::dmem_word_aw+2:3];
  assign lane = offset[2:0];

  always_comb begin
    case (mem_op)
      rv_pkg::mem_h, rv_pkg::mem_hu: nbytes = 4'd2;
      rv_pkg::mem_w, rv_pkg::mem_wu: nbytes = 4'd4;
      rv_pkg::mem_d:                 nbytes = 4'd8;
      default:                       nbytes = 4'd1;
    endcase
  end

  assign ok = (offset < 64'(rv_pkg::dmem_bytes)) && ((lane & 3'(nbytes - 4'd1)) == 3'd0);
  assign wr_error = mem_wr && !ok; // sampled by core same cycle
  assign size_mask = 8'((9'd1 << nbytes) - 9'd1);
  assign wmask = size_mask << lane;                 // byte enables
  assign wshift = wr_data << {lane, 3'b000};
  assign rword = ram[idx] >> {lane, 3'b000};        // access moved to bit 0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**rv_pkg::dmem_word_aw; i++) begin
        ram[i] <= 64'd0;
      end
    end else if (mem_wr && ok) begin
      for (int b = 0; b < 8; b++) begin
        if (wmask[b]) ram[idx][8*b +: 8] <= wshift[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
      rd_error <= 1'b0;
    end else begin
      rd_valid <= mem_rd && ok;
      rd_error <= mem_rd && !ok;
    end
  end

  // sized load with extension
  always_ff @(posedge clk) begin
    if (mem_rd) begin
      case (mem_op)
        rv_pkg::mem_b:  rd_data <= {{56{rword[7]}}, rword[7:0]};
        rv_pkg::mem_h:  rd_data <= {{48{rword[15]}}, rword[15:0]};
        rv_pkg::mem_w:  rd_data <= {{32{rword[31]}}, rword[31:0]};
        rv_pkg::mem_bu: rd_data <= {56'd0, rword[7:0]};
        rv_pkg::mem_hu: rd_data <= {48'd0, rword[15:0]};
        rv_pkg::mem_wu: rd_data <= {32'd0, rword[31:0]};
        default:        rd_data <= rword; // ld
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_top (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       load_valid,
  input  wire logic [rv_pkg::imem_aw-1:0] load_addr,
  input  wire logic [31:0]                load_data,
  output logic                            retire_valid,
  output logic      [63:0]                retire_pc,
  output logic      [4:0]                 retire_rd,
  output logic      [63:0]                retire_data,
  output logic      [63:0]                pc_done,
  output logic                            done,
  output logic                            error,
  output logic      [63:0]                mepc,
  output logic      [63:0]                mcause
);

  logic fetch_req, instr_valid, instr_error;     // fetch path
  logic [63:0] fetch_pc;
  logic [31:0] instr;
  logic mem_rd, mem_wr, rd_valid, rd_error, wr_error; // data path
  logic [63:0] mem_addr, wr_data, rd_data;
  rv_pkg::mem_op_e mem_op;

  rv_core u_core (
    .clk(clk), .rst(rst),
    .fetch_req(fetch_req), .fetch_pc(fetch_pc),
    .instr_valid(instr_valid), .instr(instr), .instr_error(instr_error),
    .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_op(mem_op),
    .wr_data(wr_data), .rd_valid(rd_valid), .rd_data(rd_data),
    .rd_error(rd_error), .wr_error(wr_error),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data),
    .pc_done(pc_done), .done(done), .error(error), .mepc(mepc), .mcause(mcause)
  );

  rv_imem u_imem (
    .clk(clk), .rst(rst),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data), // program loader
    .fetch_req(fetch_req), .fetch_pc(fetch_pc),
    .instr_valid(instr_valid), .instr(instr), .instr_error(instr_error)
  );

  rv_dmem u_dmem (
    .clk(clk), .rst(rst),
    .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_op(mem_op),
    .wr_data(wr_data), .rd_valid(rd_valid), .rd_data(rd_data),
    .rd_error(rd_error), .wr_error(wr_error)
  );

endmodule

`default_nettype wire

// File: tests/rv_top_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rv_top_checker (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic       fetch_req,
  input wire logic       instr_valid,
  input wire logic       instr_error,
  input wire logic       mem_rd,
  input wire logic       mem_wr,
  input wire logic       retire_valid,
  input wire logic [2:0] state,
  input wire logic       done,
  input wire logic       error
);

  int assert_fails = 0; // read by the testbench at the end

  fetch_answer_a: assert property (@(posedge clk) disable iff (rst)
    fetch_req |=> (instr_valid || instr_error))
    else begin $error("no fetch answer one cycle after fetch_req"); assert_fails++; end

  valid_after_req_a: assert property (@(posedge clk) disable iff (rst)
    instr_valid |-> $past(fetch_req))
    else begin $error("instr_valid without fetch_req"); assert_fails++; end

  rd_wr_excl_a: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
    else begin $error("mem_rd and mem_wr together"); assert_fails++; end

  no_retire_halt_a: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> (state != rv_pkg::halt_st))
    else begin $error("retire in halt_st"); assert_fails++; end

  status_excl_a: assert property (@(posedge clk) disable iff (rst) !(done && error))
    else begin $error("done and error both high"); assert_fails++; end

endmodule

bind rv_core rv_top_checker u_checker (
  .clk(clk), .rst(rst), .fetch_req(fetch_req),
  .instr_valid(instr_valid), .instr_error(instr_error),
  .mem_rd(mem_rd), .mem_wr(mem_wr), .retire_valid(retire_valid),
  .state(state), .done(done), .error(error)
);

`default_nettype wire

// File: tests/rv_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_top_tb;

  logic clk;
  logic rst;
  logic load_valid;
  logic [rv_pkg::imem_aw-1:0] load_addr;
  logic [31:0] load_data;
  logic retire_valid;
  logic [63:0] retire_pc;
  logic [4:0] retire_rd;
  logic [63:0] retire_data;
  logic [63:0] pc_done;
  logic done;
  logic error;
  logic [63:0] mepc;
  logic [63:0] mcause;

  logic [63:0] gold [0:255];  // flat golden stream
  int ptr;                    // read position in gold
  int limit_cycles = 0;       // watchdog budget stays 0 until known

  rv_top uut (
    .clk(clk), .rst(rst),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data),
    .pc_done(pc_done), .done(done), .error(error), .mepc(mepc), .mcause(mcause)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERR %s: expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // cycles for all cases from word and record counts
  function automatic int budget_cycles();
    int p;
    int cycles;
    p = 1;
    cycles = 0;
    for (int c = 0; c < int'(gold[0]); c++) begin
      cycles += int'(gold[p]) + 10;        // reset and load
      p += 1 + int'(gold[p]);
      cycles += 4 * int'(gold[p]) + 100;   // worst case 4 per instr
      p += 1 + 3 * int'(gold[p]) + 5;
    end
    return cycles;
  endfunction

  // core held in reset while the rom fills
  task automatic load_program(input int base, input int nwords);
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    for (int i = 0; i < nwords; i++) begin
      @(posedge clk);
      load_valid <= 1'b1;
      load_addr <= i[rv_pkg::imem_aw-1:0];
      load_data <= gold[base + i][31:0];
    end
    @(posedge clk);
    load_valid <= 1'b0;
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_case(input int cnum);
    int nwords;
    int nrec;
    int rec_base;
    int seen;
    string tag;
    nwords = int'(gold[ptr]);
    @(posedge clk);
    load_program(ptr + 1, nwords);
    ptr = ptr + 1 + nwords;
    nrec = int'(gold[ptr]);
    rec_base = ptr + 1;
    ptr = rec_base + 3 * nrec; // now at status block
    seen = 0;
    while (!(done || error)) begin
      @(negedge clk); // outputs settled here
      if (retire_valid) begin
        if (seen >= nrec) begin
          abort_run($sformatf("case%0d retired more instructions than expected", cnum));
        end else begin
          tag = $sformatf("case%0d retire %0d", cnum, seen);
          check_value({tag, " pc"}, gold[rec_base + 3 * seen], retire_pc);
          check_value({tag, " rd"}, gold[rec_base + 3 * seen + 1], 64'(retire_rd));
          check_value({tag, " data"}, gold[rec_base + 3 * seen + 2], retire_data);
          seen++;
        end
      end
    end
    tag = $sformatf("case%0d halt", cnum);
    check_value({tag, " retire count"}, 64'(nrec), 64'(seen));
    check_value({tag, " done"}, gold[ptr], 64'(done));
    check_value({tag, " error"}, gold[ptr + 1], 64'(error));
    check_value({tag, " pc_done"}, gold[ptr + 2], pc_done);
    check_value({tag, " mepc"}, gold[ptr + 3], mepc);
    check_value({tag, " mcause"}, gold[ptr + 4], mcause);
    ptr = ptr + 5;
  endtask

  initial begin
    rst = 1'b1;
    load_valid = 1'b0;
    load_addr = '0;
    load_data = 32'd0;
    $readmemh("tests/rv_golden.hex", gold);
    if ($isunknown(gold[0])) begin
      abort_run("golden file tests/rv_golden.hex could not be read");
    end else begin
      limit_cycles = budget_cycles();
      ptr = 1;
      for (int c = 1; c <= int'(gold[0]); c++) begin
        run_case(c);
      end
      if (uut.u_core.u_checker.assert_fails == 0) begin
        $display("Test passed");
        $finish;
      end else begin
        $display("bound protocol assertions failed %0d times",
                 uut.u_core.u_checker.assert_fails);
        $display("Test failed");
        $fatal(1, "protocol assertions failed");
      end
    end
  end

  // stops at the first protocol violation
  initial begin
    wait (uut.u_core.u_checker.assert_fails != 0);
    $display("bound protocol assertion failed during the run");
    $display("Test failed");
    $fatal(1, "protocol assertion failed");
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: core never halted within %0d cycles", limit_cycles);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: tests/rv_golden.hex
// case count, then per case: word count, program words, record count,
// records as pc rd data, status as done error pc_done mepc mcause
2
// case 1: alu, memory, branches, jal, ecall and mret, ends on ebreak at 0x80
28
FFF00093 00500113 002081B3 40200233 // 00 addi addi add sub
00708013 800002B7 00001337 123453B7 // 10 addi x0, lui x5 x6 x7
67838393 00433023 00732423 00731623 // 20 addi, sd sw sh
00230723 00033403 00832483 00C32503 // 30 sb, ld lw lw
00036583 00231603 00035683 00030703 // 40 lwu lh lhu lb
00034783 00208463 00209463 00100073 // 50 lbu beq bne, skipped
00210463 00100073 00211463 0080086F // 60 beq, skipped, bne jal
00100073 09000893 30589073 00000073 // 70 skipped, addi csrrw ecall
00100073 00000000 00000000 00000000 // 80 ebreak, unused
34101973 00490913 34191073 30200073 // 90 trap handler
21
00 01 FFFFFFFFFFFFFFFF
04 02 5
08 03 4
0C 04 FFFFFFFFFFFFFFFB
10 00 0
14 05 FFFFFFFF80000000
18 06 1000
1C 07 12345000
20 07 12345678
24 00 0
28 00 0
2C 00 0
30 00 0
34 08 FFFFFFFFFFFFFFFB
38 09 12345678
3C 0A 55678
40 0B FFFFFFFB
44 0C FFFFFFFFFFFFFFFF
48 0D FFFB
4C 0E FFFFFFFFFFFFFFFB
50 0F FB
54 00 0
58 00 0
60 00 0
68 00 0
6C 10 70
74 11 90
78 00 0
7C 00 0
90 12 7C
94 12 80
98 00 0
9C 00 0
1 0 80 80 B
// case 2: misaligned ld faults at 0x04
3
000010B7 0040B103 00100073
1
00 01 1000
0 1 4 0 0

// File: rv_core.f
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_csr.sv
logic/rv_core.sv
logic/rv_imem.sv
logic/rv_dmem.sv
logic/rv_top.sv
tests/rv_top_checker.sv
tests/rv_top_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/rv_regfile.sv
  - logic/rv_csr.sv
  - logic/rv_core.sv
  - logic/rv_imem.sv
  - logic/rv_dmem.sv
  - logic/rv_top.sv
  - target: test
    files:
      - tests/rv_top_checker.sv
      - tests/rv_top_tb.sv
